// ==== Makefile ====
TOP = mipsCoreTb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --top-module $(TOP) -f mipsCore.f -Mdir obj_dir

run: compile
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "TESTS PASSED"

clean:
	rm -rf obj_dir

// ==== alu.sv ====
`timescale 1ns/1ps
`include "mips_consts.svh"

module alu
    import mipsCtrlPkg::*;
(
    input  aluCtrlT                 aluCtrl,
    input  logic [`MIPS_WORD_W-1:0] a,
    input  logic [`MIPS_WORD_W-1:0] b,
    output logic [`MIPS_WORD_W-1:0] result,
    output logic                    zero
);

    logic lessThan;

    assign lessThan = $signed(a) < $signed(b);  // Two's complement compare

    always_comb begin
        case (aluCtrl)
            ALU_AND: result = a & b;
            ALU_OR:  result = a | b;
            ALU_ADD: result = a + b;
            ALU_SUB: result = a - b;
            ALU_SLT: result = {{(`MIPS_WORD_W-1){1'b0}}, lessThan};
            default: result = '0;
        endcase
    end

    assign zero = (result == '0);

endmodule

// ==== aluControl.sv ====
`timescale 1ns/1ps

module aluControl
    import mipsIsaPkg::*, mipsCtrlPkg::*;
(
    input  aluOpT   aluOp,
    input  functT   funct,
    output aluCtrlT aluCtrl
);

    always_comb begin
        case (aluOp)
            ALUOP_ADD: aluCtrl = ALU_ADD;
            ALUOP_SUB: aluCtrl = ALU_SUB;
            ALUOP_FUNCT: begin
                case (funct)
                    FN_ADD:  aluCtrl = ALU_ADD;
                    FN_SUB:  aluCtrl = ALU_SUB;
                    FN_AND:  aluCtrl = ALU_AND;
                    FN_OR:   aluCtrl = ALU_OR;
                    FN_SLT:  aluCtrl = ALU_SLT;
                    default: aluCtrl = ALU_ADD;  // Unsupported funct
                endcase
            end
            default: aluCtrl = ALU_ADD;
        endcase
    end

endmodule

// ==== controlUnit.sv ====
`timescale 1ns/1ps

module controlUnit
    import mipsIsaPkg::*, mipsCtrlPkg::*;
(
    input  opcodeT opcode,
    output ctrlT   ctrl
);

    always_comb begin
        ctrl = '0;  // Unknown opcodes fall through as a no-op
        case (opcode)
            OP_RTYPE: begin
                ctrl.regDst   = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.aluOp    = ALUOP_FUNCT;
            end
            OP_LW: begin
                ctrl.aluSrc   = 1'b1;
                ctrl.memToReg = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.memRead  = 1'b1;
                ctrl.aluOp    = ALUOP_ADD;  // Base plus offset
            end
            OP_SW: begin
                ctrl.aluSrc   = 1'b1;
                ctrl.memWrite = 1'b1;
                ctrl.aluOp    = ALUOP_ADD;
            end
            OP_BEQ: begin
                ctrl.branch   = 1'b1;
                ctrl.aluOp    = ALUOP_SUB;  // Zero flag means equal
            end
            OP_ADDI: begin
                ctrl.aluSrc   = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.aluOp    = ALUOP_ADD;
            end
            default: begin
                ctrl = '0;
            end
        endcase
    end

endmodule

// ==== dataMemory.sv ====
`timescale 1ns/1ps
`include "mips_consts.svh"

module dataMemory (
    input  logic clk,
    input  logic rstN,
    memIf.memory mem
);

    localparam int IdxW = $clog2(`MIPS_DMEM_WORDS);

    logic [`MIPS_WORD_W-1:0] ram [`MIPS_DMEM_WORDS];
    logic [IdxW-1:0]         wordIdx;

    // Drop the byte offset, upper bits wrap around
    assign wordIdx = mem.addr[`MIPS_BYTE_OFS_W +: IdxW];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < `MIPS_DMEM_WORDS; i++) begin
                ram[i] <= '0;
            end
        end else if (mem.writeEn) begin
            ram[wordIdx] <= mem.wdata;
        end
    end

    assign mem.rdata = mem.readEn ? ram[wordIdx] : '0;  // Same-cycle load data

endmodule

// ==== memIf.sv ====
`timescale 1ns/1ps
`include "mips_consts.svh"

interface memIf;

    logic [`MIPS_WORD_W-1:0] addr;     // Byte address
    logic [`MIPS_WORD_W-1:0] wdata;
    logic [`MIPS_WORD_W-1:0] rdata;    // Zero unless readEn
    logic                    writeEn;  // Strobe, lands on the rising edge
    logic                    readEn;

    modport core (
        output addr,
        output wdata,
        output writeEn,
        output readEn,
        input  rdata
    );

    modport memory (
        input  addr,
        input  wdata,
        input  writeEn,
        input  readEn,
        output rdata
    );

endinterface

// ==== mipsCore.f ====
+incdir+.
mipsIsaPkg.sv
mipsCtrlPkg.sv
memIf.sv
controlUnit.sv
aluControl.sv
alu.sv
registerFile.sv
dataMemory.sv
mipsCore.sv
tbClockGen.sv
mipsCoreTb.sv

// ==== mipsCore.sv ====
`timescale 1ns/1ps
`include "mips_consts.svh"

module mipsCore
    import mipsIsaPkg::*, mipsCtrlPkg::*;
(
    input  logic                        clk,
    input  logic                        rstN,
    output logic [`MIPS_WORD_W-1:0]     pc,
    input  logic [`MIPS_WORD_W-1:0]     instr,
    output logic                        regWriteEn,
    output logic [`MIPS_REG_ADDR_W-1:0] regWriteAddr,
    output logic [`MIPS_WORD_W-1:0]     regWriteData,
    output logic                        memWriteEn,
    output logic [`MIPS_WORD_W-1:0]     memAddr,
    output logic [`MIPS_WORD_W-1:0]     memWriteData
);

    instrU                   instrWord;
    ctrlT                    ctrl;
    aluCtrlT                 aluCtrl;
    logic [`MIPS_WORD_W-1:0] rsData;
    logic [`MIPS_WORD_W-1:0] rtData;
    logic [`MIPS_WORD_W-1:0] signExtImm;
    logic [`MIPS_WORD_W-1:0] aluB;
    logic [`MIPS_WORD_W-1:0] aluResult;
    logic                    aluZero;
    logic [`MIPS_WORD_W-1:0] pcPlus4;
    logic [`MIPS_WORD_W-1:0] branchTarget;
    logic [`MIPS_WORD_W-1:0] nextPc;
    logic                    branchTaken;

    memIf dmemBus ();

    assign instrWord = instr;  // Fetched word as R and I views

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pc <= `MIPS_RESET_PC;
        end else begin
            pc <= nextPc;
        end
    end

    controlUnit uControl (
        .opcode (instrWord.i.opcode),
        .ctrl   (ctrl)
    );

    aluControl uAluControl (
        .aluOp   (ctrl.aluOp),
        .funct   (instrWord.r.funct),
        .aluCtrl (aluCtrl)
    );

    registerFile uRegFile (
        .clk       (clk),
        .rstN      (rstN),
        .readAddrA (instrWord.r.rs),
        .readAddrB (instrWord.r.rt),
        .readDataA (rsData),
        .readDataB (rtData),
        .writeEn   (regWriteEn),
        .writeAddr (regWriteAddr),
        .writeData (regWriteData)
    );

    assign signExtImm = {{(`MIPS_WORD_W-16){instrWord.i.imm[15]}}, instrWord.i.imm};
    assign aluB       = ctrl.aluSrc ? signExtImm : rtData;

    alu uAlu (
        .aluCtrl (aluCtrl),
        .a       (rsData),
        .b       (aluB),
        .result  (aluResult),
        .zero    (aluZero)
    );

    // Data memory access, writes held off during reset
    assign dmemBus.addr    = aluResult;
    assign dmemBus.wdata   = rtData;
    assign dmemBus.writeEn = ctrl.memWrite & rstN;
    assign dmemBus.readEn  = ctrl.memRead;

    dataMemory uDataMem (
        .clk  (clk),
        .rstN (rstN),
        .mem  (dmemBus.memory)
    );

    // Writeback path, rd for R-type and rt otherwise
    assign regWriteEn   = ctrl.regWrite & rstN;
    assign regWriteAddr = ctrl.regDst ? instrWord.r.rd : instrWord.r.rt;
    assign regWriteData = ctrl.memToReg ? dmemBus.rdata : aluResult;

    // Store trace
    assign memWriteEn   = dmemBus.writeEn;
    assign memAddr      = dmemBus.addr;
    assign memWriteData = dmemBus.wdata;

    assign pcPlus4      = pc + 32'd4;
    assign branchTarget = pcPlus4 + {signExtImm[`MIPS_WORD_W-3:0], 2'b00};
    assign branchTaken  = ctrl.branch & aluZero;  // beq with equal operands
    assign nextPc       = branchTaken ? branchTarget : pcPlus4;

endmodule

// ==== mipsCoreTb.sv ====
`timescale 1ns/1ps
`include "mips_consts.svh"

module mipsCoreTb
    import mipsIsaPkg::*;
();

    localparam int          ResetCycles   = 5;
    localparam int          FixedWords    = 18;
    localparam int          RandomWords   = 40;
    localparam int          ProgWords     = FixedWords + RandomWords;
    localparam int          TimeoutCycles = ProgWords + ResetCycles + 57;  // 120 cycles
    localparam int          RomWords      = 64;
    localparam int          RomIdxW       = $clog2(RomWords);
    localparam int          MemIdxW       = $clog2(`MIPS_DMEM_WORDS);
    localparam logic [31:0] EndPc         = 32'(ProgWords * 4);
    localparam int unsigned Seed          = 32'hd709_18c8;

    // Expected effect of one instruction
    typedef struct packed {
        logic [31:0] nextPc;
        logic        regWe;
        logic [4:0]  regAddr;
        logic [31:0] regData;
        logic        memWe;
        logic [31:0] memAddr;
        logic [31:0] memData;
    } stepT;

    logic                    clk;
    logic                    rstN;
    logic [`MIPS_WORD_W-1:0] pc;
    logic [`MIPS_WORD_W-1:0] instr;
    logic                    regWriteEn;
    logic [4:0]              regWriteAddr;
    logic [`MIPS_WORD_W-1:0] regWriteData;
    logic                    memWriteEn;
    logic [`MIPS_WORD_W-1:0] memAddr;
    logic [`MIPS_WORD_W-1:0] memWriteData;

    logic [31:0] rom [RomWords];
    logic [31:0] refRegs [32];
    logic [31:0] refMem [`MIPS_DMEM_WORDS];
    logic [31:0] expectedPc;
    logic [31:0] firstWord;
    int          cycleCount;

    tbClockGen #(.PeriodNs(8), .ResetCycles(ResetCycles)) uClockGen (
        .clk  (clk),
        .rstN (rstN)
    );

    assign instr = rom[pc[RomIdxW+1:2]];  // Fetch answers in the same cycle

    mipsCore dut (
        .clk          (clk),
        .rstN         (rstN),
        .pc           (pc),
        .instr        (instr),
        .regWriteEn   (regWriteEn),
        .regWriteAddr (regWriteAddr),
        .regWriteData (regWriteData),
        .memWriteEn   (memWriteEn),
        .memAddr      (memAddr),
        .memWriteData (memWriteData)
    );

    function automatic logic [31:0] encodeR(functT fn, logic [4:0] rd, logic [4:0] rs,
                                            logic [4:0] rt);
        instrU w;
        w.r.opcode = OP_RTYPE;
        w.r.rs     = rs;
        w.r.rt     = rt;
        w.r.rd     = rd;
        w.r.shamt  = 5'd0;
        w.r.funct  = fn;
        return w;
    endfunction

    function automatic logic [31:0] encodeI(opcodeT op, logic [4:0] rt, logic [4:0] rs,
                                            logic [15:0] imm);
        instrU w;
        w.i.opcode = op;
        w.i.rs     = rs;
        w.i.rt     = rt;
        w.i.imm    = imm;
        return w;
    endfunction

    // Instruction-set model on refRegs and refMem
    function automatic stepT modelStep(input logic [31:0] curPc, input instrU w);
        stepT        s;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] immExt;
        logic [31:0] ea;
        s      = '0;
        a      = refRegs[w.r.rs];
        b      = refRegs[w.r.rt];
        immExt = {{16{w.i.imm[15]}}, w.i.imm};
        ea     = a + immExt;  // Byte address of lw and sw
        s.nextPc = curPc + 32'd4;
        case (w.i.opcode)
            OP_RTYPE: begin
                s.regWe   = 1'b1;
                s.regAddr = w.r.rd;
                case (w.r.funct)
                    FN_SUB:  s.regData = a - b;
                    FN_AND:  s.regData = a & b;
                    FN_OR:   s.regData = a | b;
                    FN_SLT:  s.regData = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    default: s.regData = a + b;  // FN_ADD and unknown funct
                endcase
            end
            OP_ADDI: begin
                s.regWe   = 1'b1;
                s.regAddr = w.i.rt;
                s.regData = a + immExt;
            end
            OP_LW: begin
                s.regWe   = 1'b1;
                s.regAddr = w.i.rt;
                s.regData = refMem[ea[2 +: MemIdxW]];
            end
            OP_SW: begin
                s.memWe   = 1'b1;
                s.memAddr = ea;
                s.memData = b;
            end
            OP_BEQ: begin
                if (a == b) begin
                    s.nextPc = curPc + 32'd4 + {immExt[29:0], 2'b00};
                end
            end
            default: ;  // Unknown opcode does nothing
        endcase
        return s;
    endfunction

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (actual !== expected) begin
            $display("[ERROR] %0t ns: %s expected 0x%08h, got 0x%08h",
                     $time, name, expected, actual);
            $display("TESTS FAILED");
            $fatal(1, "Stopping at first mismatch");
        end
    endtask

    task automatic loadProgram();
        logic [31:0] rnd;
        int unsigned kind;
        int unsigned span;
        logic [15:0] off;
        for (int k = 0; k < RomWords; k++) begin
            rom[k] = '0;  // add $0, $0, $0
        end
        rom[0]  = encodeI(OP_ADDI, 5'd1, 5'd0, 16'd5);
        rom[1]  = encodeI(OP_ADDI, 5'd2, 5'd0, 16'hFFFD);  // -3
        rom[2]  = encodeR(FN_ADD, 5'd3, 5'd1, 5'd2);
        rom[3]  = encodeR(FN_SUB, 5'd4, 5'd1, 5'd2);
        rom[4]  = encodeR(FN_AND, 5'd5, 5'd1, 5'd4);
        rom[5]  = encodeR(FN_OR,  5'd6, 5'd1, 5'd4);
        rom[6]  = encodeR(FN_SLT, 5'd7, 5'd2, 5'd1);   // Negative less than positive
        rom[7]  = encodeR(FN_SLT, 5'd8, 5'd1, 5'd2);
        rom[8]  = encodeI(OP_SW, 5'd6, 5'd0, 16'd8);
        rom[9]  = encodeI(OP_LW, 5'd9, 5'd0, 16'd8);
        rom[10] = encodeI(OP_ADDI, 5'd0, 5'd0, 16'd7);  // Write to $zero
        rom[11] = encodeR(FN_ADD, 5'd11, 5'd0, 5'd1);
        rom[12] = encodeI(OP_BEQ, 5'd9, 5'd1, 16'd2);  // Not taken
        rom[13] = encodeI(OP_BEQ, 5'd6, 5'd9, 16'd2);  // Taken, skips two
        rom[14] = encodeI(OP_ADDI, 5'd12, 5'd0, 16'd1);
        rom[15] = encodeI(OP_ADDI, 5'd12, 5'd0, 16'd2);
        rom[16] = 32'hFC00_0000;  // Unknown opcode
        rom[17] = encodeR(FN_SLT, 5'd13, 5'd2, 5'd0);
        for (int k = FixedWords; k < ProgWords; k++) begin
            rnd  = $urandom;
            kind = $urandom % 9;
            span = ProgWords - k;
            off  = 16'($urandom % ((span < 4) ? span : 4));  // Forward, stays in program
            case (kind)
                0: rom[k] = encodeR(FN_ADD, rnd[14:10], rnd[4:0], rnd[9:5]);
                1: rom[k] = encodeR(FN_SUB, rnd[14:10], rnd[4:0], rnd[9:5]);
                2: rom[k] = encodeR(FN_AND, rnd[14:10], rnd[4:0], rnd[9:5]);
                3: rom[k] = encodeR(FN_OR,  rnd[14:10], rnd[4:0], rnd[9:5]);
                4: rom[k] = encodeR(FN_SLT, rnd[14:10], rnd[4:0], rnd[9:5]);
                5: rom[k] = encodeI(OP_ADDI, rnd[9:5], rnd[4:0], rnd[31:16]);
                6: rom[k] = encodeI(OP_LW,   rnd[9:5], rnd[4:0], rnd[31:16]);
                7: rom[k] = encodeI(OP_SW,   rnd[9:5], rnd[4:0], rnd[31:16]);
                default: rom[k] = encodeI(OP_BEQ, rnd[9:5], rnd[4:0], off);
            endcase
        end
    endtask

    initial begin
        stepT step;
        bit   done;
        void'($urandom(Seed));
        expectedPc = `MIPS_RESET_PC;
        done       = 1'b0;
        for (int k = 0; k < 32; k++) begin
            refRegs[k] = '0;
        end
        for (int k = 0; k < `MIPS_DMEM_WORDS; k++) begin
            refMem[k] = '0;
        end
        loadProgram();
        // A store sits at pc 0 for the first reset cycle, then the program word
        firstWord = rom[0];
        rom[0]    = encodeI(OP_SW, 5'd0, 5'd0, 16'd0);
        while (!done) begin
            @(posedge clk);
            #2;
            if (!rstN) begin
                checkValue("pc", `MIPS_RESET_PC, pc);
                checkValue("regWriteEn", 32'(1'b0), 32'(regWriteEn));
                checkValue("memWriteEn", 32'(1'b0), 32'(memWriteEn));
                rom[0] = firstWord;
            end else begin
                checkValue("pc", expectedPc, pc);
                if (pc >= EndPc) begin
                    done = 1'b1;
                end else begin
                    step = modelStep(pc, instr);
                    checkValue("regWriteEn", 32'(step.regWe), 32'(regWriteEn));
                    if (step.regWe) begin
                        checkValue("regWriteAddr", 32'(step.regAddr), 32'(regWriteAddr));
                        checkValue("regWriteData", step.regData, regWriteData);
                        if (step.regAddr != 5'd0) begin
                            refRegs[step.regAddr] = step.regData;
                        end
                    end
                    checkValue("memWriteEn", 32'(step.memWe), 32'(memWriteEn));
                    if (step.memWe) begin
                        checkValue("memAddr", step.memAddr, memAddr);
                        checkValue("memWriteData", step.memData, memWriteData);
                        refMem[step.memAddr[2 +: MemIdxW]] = step.memData;
                    end
                    expectedPc = step.nextPc;
                end
            end
        end
        $display("TESTS PASSED");
        $finish;
    end

    initial begin
        cycleCount = 0;
        forever begin
            @(posedge clk);
            cycleCount++;
            if (cycleCount > TimeoutCycles) begin
                $display("Timeout: program did not finish within %0d cycles", TimeoutCycles);
                $display("TESTS FAILED");
                $fatal(1, "Timeout");
            end
        end
    end

endmodule

// ==== mipsCtrlPkg.sv ====
package mipsCtrlPkg;

    // Operation class chosen by the main decoder
    typedef enum logic [1:0] {
        ALUOP_ADD   = 2'b00,  // Address calc and addi
        ALUOP_SUB   = 2'b01,  // Compare for beq
        ALUOP_FUNCT = 2'b10   // Look at funct field
    } aluOpT;

    // Operation actually performed by the ALU
    typedef enum logic [3:0] {
        ALU_AND = 4'b0000,
        ALU_OR  = 4'b0001,
        ALU_ADD = 4'b0010,
        ALU_SUB = 4'b0110,
        ALU_SLT = 4'b0111
    } aluCtrlT;

    // Datapath control for one instruction
    typedef struct packed {
        logic  regDst;    // 1 selects rd, 0 selects rt
        logic  aluSrc;    // 1 selects immediate
        logic  memToReg;  // 1 writes back load data
        logic  regWrite;
        logic  memRead;
        logic  memWrite;
        logic  branch;
        aluOpT aluOp;
    } ctrlT;

endpackage

// ==== mipsIsaPkg.sv ====
package mipsIsaPkg;

    // Primary opcode field, bits 31:26
    typedef enum logic [5:0] {
        OP_RTYPE = 6'b000000,
        OP_BEQ   = 6'b000100,
        OP_ADDI  = 6'b001000,
        OP_LW    = 6'b100011,
        OP_SW    = 6'b101011
    } opcodeT;

    // Function field of R-type words, bits 5:0
    typedef enum logic [5:0] {
        FN_ADD = 6'b100000,
        FN_SUB = 6'b100010,
        FN_AND = 6'b100100,
        FN_OR  = 6'b100101,
        FN_SLT = 6'b101010
    } functT;

    typedef struct packed {
        opcodeT      opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [4:0]  shamt;   // Unused, no shifts supported
        functT       funct;
    } rFmtT;

    typedef struct packed {
        opcodeT      opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;     // Sign-extended by the core
    } iFmtT;

    // One fetched word, seen as either format
    typedef union packed {
        rFmtT r;
        iFmtT i;
    } instrU;

endpackage

// ==== mips_consts.svh ====
`ifndef MIPS_CONSTS_SVH
`define MIPS_CONSTS_SVH

// Datapath and instruction word width
`define MIPS_WORD_W 32

// Register file geometry
`define MIPS_REG_COUNT 32
`define MIPS_REG_ADDR_W 5

// Data memory depth in 32-bit words
`define MIPS_DMEM_WORDS 256

// Byte offset bits below the word index
`define MIPS_BYTE_OFS_W 2

// First fetch address after reset
`define MIPS_RESET_PC 32'h0000_0000

`endif

// ==== registerFile.sv ====
`timescale 1ns/1ps
`include "mips_consts.svh"

module registerFile (
    input  logic                        clk,
    input  logic                        rstN,
    input  logic [`MIPS_REG_ADDR_W-1:0] readAddrA,
    input  logic [`MIPS_REG_ADDR_W-1:0] readAddrB,
    output logic [`MIPS_WORD_W-1:0]     readDataA,
    output logic [`MIPS_WORD_W-1:0]     readDataB,
    input  logic                        writeEn,
    input  logic [`MIPS_REG_ADDR_W-1:0] writeAddr,
    input  logic [`MIPS_WORD_W-1:0]     writeData
);

    logic [`MIPS_WORD_W-1:0] regs [`MIPS_REG_COUNT];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < `MIPS_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn && (writeAddr != '0)) begin  // $zero stays zero
            regs[writeAddr] <= writeData;
        end
    end

    // Register zero reads as a constant
    assign readDataA = (readAddrA == '0) ? '0 : regs[readAddrA];
    assign readDataB = (readAddrB == '0) ? '0 : regs[readAddrB];

endmodule

// ==== tbClockGen.sv ====
`timescale 1ns/1ps

module tbClockGen #(
    parameter int PeriodNs    = 8,
    parameter int ResetCycles = 5
) (
    output logic clk,
    output logic rstN
);

    initial begin
        clk = 1'b0;
        forever #(PeriodNs / 2) clk = ~clk;
    end

    initial begin
        rstN = 1'b0;
        repeat (ResetCycles) @(posedge clk);
        #1 rstN = 1'b1;  // Released just after the edge
    end

endmodule
